//--- verilog/udp_echo_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and constants of the UDP echo core
// IP checksum, DSCP and ECN are not carried
// Register map is byte addressed on a 32-bit APB bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package udp_echo_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [7:0]  ttl_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] count_t;
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Header as it arrives from the UDP parser
    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        udp_len_t  length;
    } udp_hdr_t;

    // Header handed to the UDP transmit side
    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        udp_len_t  length;
        ttl_t      ttl;
    } echo_hdr_t;

    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } pay_beat_t;

    typedef struct packed {
        ip_addr_t  local_ip;
        udp_port_t echo_port;
        ttl_t      ttl;
    } echo_cfg_t;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;

    localparam apb_addr_t REG_LOCAL_IP  = 8'h00;
    localparam apb_addr_t REG_ECHO_PORT = 8'h04;
    localparam apb_addr_t REG_TTL       = 8'h08;
    localparam apb_addr_t REG_ECHO_CNT  = 8'h0C;
    localparam apb_addr_t REG_DROP_CNT  = 8'h10;

    // 192.168.1.128
    localparam ip_addr_t  RST_LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam udp_port_t RST_ECHO_PORT = 16'd1234;
    localparam ttl_t      RST_TTL       = 8'd64;

endpackage

//--- verilog/echo_cfg_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register block, no wait states
// Counters are read only and saturate
// Unmapped or counter writes give pslverr
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module echo_cfg_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  udp_echo_pkg::apb_addr_t paddr,
    input  udp_echo_pkg::apb_data_t pwdata,
    output udp_echo_pkg::apb_data_t prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   echo_done,
    input  logic                   drop_done,
    output udp_echo_pkg::echo_cfg_t cfg
);
    import udp_echo_pkg::*;

    logic   access;
    logic   mapped;
    logic   ro_reg;
    logic   wr_en;
    count_t echo_cnt;
    count_t drop_cnt;

    assign access = psel && penable;
    assign mapped = (paddr == REG_LOCAL_IP) || (paddr == REG_ECHO_PORT) ||
                    (paddr == REG_TTL) || ro_reg;
    assign ro_reg = (paddr == REG_ECHO_CNT) || (paddr == REG_DROP_CNT);

    assign pready  = 1'b1;
    assign pslverr = access && (!mapped || (pwrite && ro_reg));
    // Only legal writes touch the configuration
    assign wr_en   = access && pwrite && !pslverr;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.local_ip  <= RST_LOCAL_IP;
            cfg.echo_port <= RST_ECHO_PORT;
            cfg.ttl       <= RST_TTL;
        end else if (wr_en) begin
            case (paddr)
                REG_LOCAL_IP:  cfg.local_ip  <= pwdata;
                REG_ECHO_PORT: cfg.echo_port <= pwdata[15:0];
                REG_TTL:       cfg.ttl       <= pwdata[7:0];
                default: ;
            endcase
        end
    end

    // Frame counters, held at all ones once full
    always_ff @(posedge clk) begin
        if (rst) begin
            echo_cnt <= '0;
            drop_cnt <= '0;
        end else begin
            if (echo_done && echo_cnt != '1)
                echo_cnt <= echo_cnt + 1'b1;
            if (drop_done && drop_cnt != '1)
                drop_cnt <= drop_cnt + 1'b1;
        end
    end

    always_comb begin
        case (paddr)
            REG_LOCAL_IP:  prdata = cfg.local_ip;
            REG_ECHO_PORT: prdata = apb_data_t'(cfg.echo_port);
            REG_TTL:       prdata = apb_data_t'(cfg.ttl);
            REG_ECHO_CNT:  prdata = apb_data_t'(echo_cnt);
            REG_DROP_CNT:  prdata = apb_data_t'(drop_cnt);
            default:       prdata = '0;
        endcase
    end

    // An error response only ends a proper setup then access sequence
    assert property (@(posedge clk) disable iff (rst)
        pslverr |-> psel && penable && $past(psel && !penable));

endmodule

//--- verilog/udp_echo_steer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Header match and turnaround, payload gate
// Header path is combinational in IDLE
// cfg must not change while a header waits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module udp_echo_steer (
    input  logic                    clk,
    input  logic                    rst,
    input  udp_echo_pkg::echo_cfg_t cfg,
    input  udp_echo_pkg::udp_hdr_t  rx_hdr,
    input  logic                    rx_hdr_valid,
    output logic                    rx_hdr_ready,
    output udp_echo_pkg::echo_hdr_t tx_hdr,
    output logic                    tx_hdr_valid,
    input  logic                    tx_hdr_ready,
    input  udp_echo_pkg::pay_beat_t rx_pay,
    input  logic                    rx_pay_valid,
    output logic                    rx_pay_ready,
    output udp_echo_pkg::pay_beat_t wr_beat,
    output logic                    wr_valid,
    input  logic                    wr_ready,
    output logic                    echo_done,
    output logic                    drop_done
);
    import udp_echo_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ECHO,
        DROP
    } state_t;

    state_t state;
    logic   port_match;
    logic   hdr_xfer;
    logic   pay_last;

    assign port_match = (rx_hdr.dst_port == cfg.echo_port);

    // Turned around header
    assign tx_hdr.src_ip   = cfg.local_ip;
    assign tx_hdr.dst_ip   = rx_hdr.src_ip;
    assign tx_hdr.src_port = rx_hdr.dst_port;
    assign tx_hdr.dst_port = rx_hdr.src_port;
    assign tx_hdr.length   = rx_hdr.length;
    assign tx_hdr.ttl      = cfg.ttl;

    assign tx_hdr_valid = (state == IDLE) && rx_hdr_valid && port_match;
    // Foreign headers are taken at once, echoed ones wait for tx
    assign rx_hdr_ready = (state == IDLE) && rx_hdr_valid && (!port_match || tx_hdr_ready);
    assign hdr_xfer     = rx_hdr_valid && rx_hdr_ready;

    assign wr_beat      = rx_pay;
    assign wr_valid     = (state == ECHO) && rx_pay_valid;
    assign rx_pay_ready = (state == DROP) || ((state == ECHO) && wr_ready);
    assign pay_last     = rx_pay_valid && rx_pay_ready && rx_pay.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            echo_done <= 1'b0;
            drop_done <= 1'b0;
        end else begin
            echo_done <= (state == ECHO) && pay_last;
            drop_done <= (state == DROP) && pay_last;
            case (state)
                IDLE: begin
                    if (hdr_xfer)
                        state <= port_match ? ECHO : DROP;
                end
                ECHO, DROP: begin
                    if (pay_last)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // A beat the FIFO cannot take stays offered in ECHO
    assert property (@(posedge clk) disable iff (rst)
        wr_valid && !wr_ready |=> state == ECHO && wr_valid && $stable(wr_beat));

    assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr));

endmodule

//--- verilog/payload_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte FIFO, FIFO_DEPTH beats
// Read data comes straight from the array
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module payload_fifo (
    input  logic                    clk,
    input  logic                    rst,
    input  udp_echo_pkg::pay_beat_t wr_beat,
    input  logic                    wr_valid,
    output logic                    wr_ready,
    output udp_echo_pkg::pay_beat_t rd_beat,
    output logic                    rd_valid,
    input  logic                    rd_ready
);
    import udp_echo_pkg::*;

    pay_beat_t          mem [FIFO_DEPTH];
    logic [FIFO_AW:0]   wr_ptr;
    logic [FIFO_AW:0]   rd_ptr;
    logic [FIFO_AW:0]   fill;
    logic               full;
    logic               empty;
    logic               wr_en;
    logic               rd_en;

    // Top pointer bit tells a full buffer from an empty one
    assign fill  = wr_ptr - rd_ptr;
    assign full  = (fill == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign empty = (fill == '0);

    assign wr_ready = !full;
    assign rd_valid = !empty;
    assign rd_beat  = mem[rd_ptr[FIFO_AW-1:0]];

    assign wr_en = wr_valid && wr_ready;
    assign rd_en = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr[FIFO_AW-1:0]] <= wr_beat;
    end

    // Stalled head beat is never overwritten
    assert property (@(posedge clk) disable iff (rst)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_beat));

    // Occupancy stays within the buffer
    assert property (@(posedge clk) disable iff (rst)
        fill <= (FIFO_AW + 1)'(FIFO_DEPTH));

endmodule

//--- verilog/udp_echo_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP echo core top level
// tx header may run ahead of its payload
// led shows first echoed byte per frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module udp_echo_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  udp_echo_pkg::apb_addr_t paddr,
    input  udp_echo_pkg::apb_data_t pwdata,
    output udp_echo_pkg::apb_data_t prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  udp_echo_pkg::udp_hdr_t  rx_hdr,
    input  logic                    rx_hdr_valid,
    output logic                    rx_hdr_ready,
    output udp_echo_pkg::echo_hdr_t tx_hdr,
    output logic                    tx_hdr_valid,
    input  logic                    tx_hdr_ready,
    input  udp_echo_pkg::pay_beat_t rx_pay,
    input  logic                    rx_pay_valid,
    output logic                    rx_pay_ready,
    output udp_echo_pkg::pay_beat_t tx_pay,
    output logic                    tx_pay_valid,
    input  logic                    tx_pay_ready,
    output udp_echo_pkg::byte_t     led
);
    import udp_echo_pkg::*;

    echo_cfg_t cfg;
    logic      echo_done;
    logic      drop_done;
    pay_beat_t wr_beat;
    logic      wr_valid;
    logic      wr_ready;
    logic      first_beat;

    echo_cfg_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .echo_done (echo_done),
        .drop_done (drop_done),
        .cfg       (cfg)
    );

    udp_echo_steer u_steer (
        .clk          (clk),
        .rst          (rst),
        .cfg          (cfg),
        .rx_hdr       (rx_hdr),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .tx_hdr       (tx_hdr),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .rx_pay       (rx_pay),
        .rx_pay_valid (rx_pay_valid),
        .rx_pay_ready (rx_pay_ready),
        .wr_beat      (wr_beat),
        .wr_valid     (wr_valid),
        .wr_ready     (wr_ready),
        .echo_done    (echo_done),
        .drop_done    (drop_done)
    );

    payload_fifo u_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_beat  (wr_beat),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .rd_beat  (tx_pay),
        .rd_valid (tx_pay_valid),
        .rd_ready (tx_pay_ready)
    );

    // First byte of each outgoing frame onto the LEDs
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= '0;
        end else if (tx_pay_valid && tx_pay_ready) begin
            if (first_beat)
                led <= tx_pay.data;
            // re-arm once the frame ends
            first_beat <= tx_pay.last;
        end
    end

endmodule

//--- sim/udp_echo_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the UDP echo core
// tx ready lines toggle only under back-pressure
// Run length is bounded by the frame table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module udp_echo_tb;
    import udp_echo_pkg::*;

    typedef struct packed {
        udp_port_t  dst_port;
        ip_addr_t   src_ip;
        udp_port_t  src_port;
        logic [3:0] len;
        logic       echo;
    } frame_row_t;

    localparam int NUM_ROWS = 16;

    // dst_port, src_ip, src_port, payload length, echoed
    frame_row_t frames [NUM_ROWS] = '{
        '{16'd1234, 32'h0a01_0203, 16'd40000, 4'd1,  1'b1},
        '{16'd1234, 32'hc0a8_0105, 16'd5353,  4'd7,  1'b1},
        '{16'd1234, 32'hac10_2001, 16'd1024,  4'd12, 1'b1},
        '{16'd80,   32'h0a01_0203, 16'd40001, 4'd5,  1'b0},
        '{16'd1235, 32'hc0a8_0199, 16'd1234,  4'd3,  1'b0},
        '{16'd5000, 32'h0a00_0001, 16'd7000,  4'd4,  1'b1},
        '{16'd1234, 32'h0a00_0002, 16'd7001,  4'd6,  1'b0},
        '{16'd5000, 32'h0a00_0003, 16'd7002,  4'd9,  1'b1},
        '{16'd5000, 32'h0a00_0004, 16'd7003,  4'd2,  1'b1},
        '{16'd5000, 32'h5566_7788, 16'd9000,  4'd12, 1'b1},
        '{16'd5000, 32'h5566_7789, 16'd9001,  4'd1,  1'b1},
        '{16'd443,  32'h5566_778a, 16'd9002,  4'd8,  1'b0},
        '{16'd5000, 32'h5566_778b, 16'd9003,  4'd11, 1'b1},
        '{16'd5000, 32'h5566_778c, 16'd9004,  4'd10, 1'b1},
        '{16'd1234, 32'h5566_778d, 16'd9005,  4'd4,  1'b0},
        '{16'd5000, 32'h5566_778e, 16'd9006,  4'd12, 1'b1}
    };

    logic      clk = 1'b0;
    logic      rst;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    udp_hdr_t  rx_hdr;
    logic      rx_hdr_valid;
    logic      rx_hdr_ready;
    echo_hdr_t tx_hdr;
    logic      tx_hdr_valid;
    logic      tx_hdr_ready;
    pay_beat_t rx_pay;
    logic      rx_pay_valid;
    logic      rx_pay_ready;
    pay_beat_t tx_pay;
    logic      tx_pay_valid;
    logic      tx_pay_ready;
    byte_t     led;

    // Reference model of the configuration and counters
    ip_addr_t    model_ip = 32'hc0a8_0180;
    udp_port_t   model_port = 16'd1234;
    ttl_t        model_ttl = 8'd64;
    count_t      model_echo = '0;
    count_t      model_drop = '0;
    echo_hdr_t   exp_hdrs [$];
    pay_beat_t   exp_beats [$];
    logic [31:0] pay_lfsr = 32'ha42e;
    logic [31:0] rdy_lfsr = 32'ha42e;
    logic        bp_on = 1'b0;
    logic        first_seen = 1'b1;
    logic        led_pending = 1'b0;
    byte_t       led_exp = '0;
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          test_errs = 0;

    udp_echo_top dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // Galois form, taps 32 22 2 1
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [8:0] rand_bits(input int n);
        logic [8:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[7:0], pay_lfsr[0]};
            pay_lfsr = lfsr_next(pay_lfsr);
        end
        return val;
    endfunction

    function automatic int table_bytes();
        int total;
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++)
            total += int'(frames[i].len);
        return total;
    endfunction

    task automatic hdr_check(input echo_hdr_t got, input echo_hdr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: tx_hdr expected %h, got %h", exp, got);
        end
    endtask

    task automatic beat_check(input pay_beat_t got, input pay_beat_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: tx_pay expected %h, got %h", exp, got);
        end
    endtask

    task automatic count_check(input string name, input count_t got, input count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic byte_check(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic word_check(input string name, input apb_data_t got, input apb_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic flag_check(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s expected %h, got %h", name, exp, got);
        end
    endtask

    // Setup then access phase, starting just after a rising edge
    task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        while (!pready)
            @(posedge clk);
        rdata = prdata;
        err   = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic reg_write(input apb_addr_t addr, input apb_data_t data);
        apb_data_t rdata;
        logic      err;
        apb_access(1'b1, addr, data, rdata, err);
        flag_check("pslverr", err, 1'b0);
    endtask

    task automatic reg_read(input apb_addr_t addr, output apb_data_t data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        flag_check("pslverr", err, 1'b0);
    endtask

    task automatic bad_access(input logic wr, input apb_addr_t addr);
        apb_data_t rdata;
        logic      err;
        apb_access(wr, addr, 32'hffff_ffff, rdata, err);
        flag_check("pslverr", err, 1'b1);
    endtask

    task automatic regs_check();
        apb_data_t rdata;
        reg_read(REG_LOCAL_IP, rdata);
        word_check("local_ip", rdata, model_ip);
        reg_read(REG_ECHO_PORT, rdata);
        word_check("echo_port", rdata, apb_data_t'(model_port));
        reg_read(REG_TTL, rdata);
        word_check("ttl", rdata, apb_data_t'(model_ttl));
        reg_read(REG_ECHO_CNT, rdata);
        count_check("echo_cnt", count_t'(rdata), model_echo);
        reg_read(REG_DROP_CNT, rdata);
        count_check("drop_cnt", count_t'(rdata), model_drop);
    endtask

    task automatic send_frame(input frame_row_t row);
        udp_hdr_t   hdr;
        echo_hdr_t  ehdr;
        pay_beat_t  beat;
        logic [8:0] bits;
        hdr.src_ip   = row.src_ip;
        hdr.dst_ip   = model_ip;
        hdr.src_port = row.src_port;
        hdr.dst_port = row.dst_port;
        hdr.length   = udp_len_t'(row.len) + 16'd8;
        // Turnaround rule for the expected header
        ehdr.src_ip   = model_ip;
        ehdr.dst_ip   = row.src_ip;
        ehdr.src_port = row.dst_port;
        ehdr.dst_port = row.src_port;
        ehdr.length   = hdr.length;
        ehdr.ttl      = model_ttl;
        if (row.echo) begin
            exp_hdrs.push_back(ehdr);
            model_echo++;
        end else begin
            model_drop++;
        end
        rx_hdr       <= hdr;
        rx_hdr_valid <= 1'b1;
        @(posedge clk);
        while (!rx_hdr_ready)
            @(posedge clk);
        rx_hdr_valid <= 1'b0;
        for (int i = 0; i < int'(row.len); i++) begin
            bits      = rand_bits(9);
            beat.data = bits[8:1];
            beat.user = bits[0];
            beat.last = (i == int'(row.len) - 1);
            if (row.echo)
                exp_beats.push_back(beat);
            rx_pay       <= beat;
            rx_pay_valid <= 1'b1;
            @(posedge clk);
            while (!rx_pay_ready)
                @(posedge clk);
        end
        rx_pay_valid <= 1'b0;
    endtask

    // Back to back frames, then wait for the tx side to drain
    task automatic run_rows(input int first, input int last);
        for (int i = first; i <= last; i++)
            send_frame(frames[i]);
        while (exp_hdrs.size() != 0 || exp_beats.size() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errs) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", tests, name, errors - test_errs);
        end
        test_errs = errors;
    endtask

    // tx scoreboard, LED check and ready pattern
    always @(posedge clk) begin
        pay_beat_t beat;
        if (!rst) begin
            if (led_pending)
                byte_check("led", led, led_exp);
            led_pending = 1'b0;
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdrs.size() == 0) begin
                    errors++;
                    $display("Unexpected tx header to port %h", tx_hdr.dst_port);
                end else begin
                    hdr_check(tx_hdr, exp_hdrs.pop_front());
                end
            end
            if (tx_pay_valid && tx_pay_ready) begin
                if (exp_beats.size() == 0) begin
                    errors++;
                    $display("Unexpected tx payload byte %h", tx_pay.data);
                end else begin
                    beat = exp_beats.pop_front();
                    beat_check(tx_pay, beat);
                    if (first_seen)
                        led_exp = beat.data;
                    first_seen  = beat.last;
                    led_pending = beat.last;
                end
            end
        end
        tx_pay_ready <= !bp_on || rdy_lfsr[0];
        rdy_lfsr = lfsr_next(rdy_lfsr);
        tx_hdr_ready <= !bp_on || rdy_lfsr[0];
        rdy_lfsr = lfsr_next(rdy_lfsr);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 40 * table_bytes() + 500) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        rx_hdr       = '0;
        rx_hdr_valid = 1'b0;
        rx_pay       = '0;
        rx_pay_valid = 1'b0;
        tx_hdr_ready = 1'b1;
        tx_pay_ready = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        flag_check("tx_hdr_valid", tx_hdr_valid, 1'b0);
        flag_check("tx_pay_valid", tx_pay_valid, 1'b0);
        flag_check("rx_hdr_ready", rx_hdr_ready, 1'b0);
        flag_check("rx_pay_ready", rx_pay_ready, 1'b0);
        byte_check("led", led, 8'h00);
        regs_check();
        end_test("reset defaults");

        run_rows(0, 2);
        regs_check();
        end_test("echo port frames");

        run_rows(3, 4);
        regs_check();
        end_test("other ports dropped");

        reg_write(REG_ECHO_PORT, 32'd5000);
        reg_write(REG_TTL, 32'd32);
        reg_write(REG_LOCAL_IP, 32'h0a0a_0001);
        model_port = 16'd5000;
        model_ttl  = 8'd32;
        model_ip   = 32'h0a0a_0001;
        run_rows(5, 8);
        regs_check();
        end_test("new configuration");

        bp_on <= 1'b1;
        run_rows(9, 15);
        bp_on <= 1'b0;
        regs_check();
        end_test("tx back-pressure");

        bad_access(1'b1, REG_ECHO_CNT);
        bad_access(1'b1, REG_DROP_CNT);
        bad_access(1'b0, 8'h14);
        bad_access(1'b1, 8'h40);
        regs_check();
        end_test("illegal accesses");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- sim.f
verilog/udp_echo_pkg.sv
verilog/echo_cfg_regs.sv
verilog/udp_echo_steer.sv
verilog/payload_fifo.sv
verilog/udp_echo_top.sv
sim/udp_echo_tb.sv

//--- Makefile
TOP := udp_echo_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f sim.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@! grep -q '\*\*\* FAILED \*\*\*' sim.log
	@grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
